//--- id_pkg.sv
/*
  shared definitions for the instruction decode stage
  width constants, decode enums, bus structs
*/
package id_pkg;

  localparam int XLEN       = 64;
  localparam int REG_ADDR_W = 5;
  // history index is pc[5:2]
  localparam int BHT_IDX_W  = 4;

  typedef enum logic [3:0] {
    cls_op_reg,
    cls_op_imm,
    cls_branch,
    cls_load,
    cls_store,
    cls_lui,
    cls_auipc,
    cls_jal,
    cls_jalr,
    cls_illegal
  } inst_class_e;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and,
    alu_lui, alu_auipc, alu_jal, alu_jalr,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu,
    alu_load, alu_store, alu_nop
  } alu_op_e;

  typedef enum logic [1:0] {
    unit_alu,
    unit_lsu,
    unit_bru,
    unit_none
  } exec_unit_e;

  typedef enum logic [1:0] {
    src_reg,
    src_pc,
    src_imm,
    src_zero
  } opnd_src_e;

  // result in flight from execute or memory
  typedef struct packed {
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       data;
  } producer_t;

  typedef struct packed {
    logic                  en;
    logic [REG_ADDR_W-1:0] addr;
  } wb_pending_t;

  typedef struct packed {
    logic                  rs1_en;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic                  rs2_en;
    logic [REG_ADDR_W-1:0] rs2_addr;
  } rf_read_t;

  typedef struct packed {
    logic            en;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                 en;
    logic [BHT_IDX_W-1:0] idx;
    logic                 taken;
  } bht_update_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    alu_op_e               alu_op;
    exec_unit_e            unit;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic                  rd_we;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       mem_addr;
    logic [2:0]            mem_size;
  } id_ex_t;

endpackage

//--- inst_decoder.sv
/*
  RV64I instruction decoder
  class, operation and unit decode, immediates,
  operand sources and register-file read request
*/
module inst_decoder import id_pkg::*; (
  input  logic [31:0]           inst_i,
  input  logic [XLEN-1:0]       pc_i,
  output inst_class_e           class_o,
  output alu_op_e               alu_op_o,
  output exec_unit_e            unit_o,
  output rf_read_t              rf_read_o,
  output opnd_src_e             src1_o,
  output opnd_src_e             src2_o,
  output logic [XLEN-1:0]       imm_o,
  output logic [XLEN-1:0]       b_imm_o,
  output logic                  rd_we_o,
  output logic [REG_ADDR_W-1:0] rd_addr_o,
  output logic [2:0]            mem_size_o
);

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111
  } opcode_e;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rd, rs1, rs2;
  logic [XLEN-1:0]       i_imm, s_imm, u_imm, br_imm, j_imm;
  logic                  shamt_ok;
  logic                  rd_wr;
  inst_class_e           cls;
  alu_op_e               alu_op;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign funct7 = inst_i[31:25];

  assign i_imm  = {{52{inst_i[31]}}, inst_i[31:20]};
  assign s_imm  = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign u_imm  = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign br_imm = {{52{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign j_imm  = {{44{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // rv64 shifts take a 6-bit shamt
  assign shamt_ok = (inst_i[31:26] == 6'b0) ||
                    (funct3 == 3'b101 && inst_i[31:26] == 6'b010000);

  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  arith_op = alt ? alu_sub : alu_add;
      3'b001:  arith_op = alu_sll;
      3'b010:  arith_op = alu_slt;
      3'b011:  arith_op = alu_sltu;
      3'b100:  arith_op = alu_xor;
      3'b101:  arith_op = alt ? alu_sra : alu_srl;
      3'b110:  arith_op = alu_or;
      default: arith_op = alu_and;
    endcase
  endfunction

  always_comb begin
    cls    = cls_illegal;
    alu_op = alu_nop;
    case (opcode)
      opc_op: begin
        if (funct7 == 7'b0 ||
            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          cls    = cls_op_reg;
          alu_op = arith_op(funct3, funct7[5]);
        end
      end
      opc_op_imm: begin
        if (funct3[1:0] != 2'b01 || shamt_ok) begin
          cls    = cls_op_imm;
          alu_op = arith_op(funct3, funct3 == 3'b101 && inst_i[30]);
        end
      end
      opc_branch: begin
        if (funct3[2:1] != 2'b01) begin
          cls = cls_branch;
          case (funct3)
            3'b000:  alu_op = alu_beq;
            3'b001:  alu_op = alu_bne;
            3'b100:  alu_op = alu_blt;
            3'b101:  alu_op = alu_bge;
            3'b110:  alu_op = alu_bltu;
            default: alu_op = alu_bgeu;
          endcase
        end
      end
      opc_load: begin
        if (funct3 != 3'b111) begin
          cls    = cls_load;
          alu_op = alu_load;
        end
      end
      opc_store: begin
        if (!funct3[2]) begin
          cls    = cls_store;
          alu_op = alu_store;
        end
      end
      opc_lui: begin
        cls    = cls_lui;
        alu_op = alu_lui;
      end
      opc_auipc: begin
        cls    = cls_auipc;
        alu_op = alu_auipc;
      end
      opc_jal: begin
        cls    = cls_jal;
        alu_op = alu_jal;
      end
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          cls    = cls_jalr;
          alu_op = alu_jalr;
        end
      end
      default: ;
    endcase
    // misaligned fetch pc
    if (pc_i[1:0] != 2'b00) begin
      cls    = cls_illegal;
      alu_op = alu_nop;
    end
  end

  always_comb begin
    unit_o     = unit_none;
    src1_o     = src_zero;
    src2_o     = src_zero;
    imm_o      = '0;
    b_imm_o    = '0;
    rd_wr      = 1'b0;
    mem_size_o = 3'b000;
    case (cls)
      cls_op_reg: begin
        unit_o = unit_alu;
        src1_o = src_reg;
        src2_o = src_reg;
        rd_wr  = 1'b1;
      end
      cls_op_imm: begin
        unit_o = unit_alu;
        src1_o = src_reg;
        src2_o = src_imm;
        imm_o  = i_imm;
        rd_wr  = 1'b1;
      end
      cls_branch: begin
        unit_o  = unit_bru;
        src1_o  = src_reg;
        src2_o  = src_reg;
        b_imm_o = br_imm;
      end
      cls_load: begin
        unit_o     = unit_lsu;
        src1_o     = src_reg;
        imm_o      = i_imm;
        rd_wr      = 1'b1;
        mem_size_o = funct3;
      end
      cls_store: begin
        unit_o     = unit_lsu;
        src1_o     = src_reg;
        src2_o     = src_reg;
        imm_o      = s_imm;
        mem_size_o = funct3;
      end
      cls_lui, cls_auipc: begin
        unit_o = unit_alu;
        src1_o = (cls == cls_auipc) ? src_pc : src_zero;
        src2_o = src_imm;
        imm_o  = u_imm;
        rd_wr  = 1'b1;
      end
      cls_jal: begin
        unit_o  = unit_bru;
        src1_o  = src_pc;
        src2_o  = src_pc;
        b_imm_o = j_imm;
        rd_wr   = 1'b1;
      end
      cls_jalr: begin
        unit_o = unit_bru;
        src1_o = src_reg;
        src2_o = src_pc;
        imm_o  = i_imm;
        rd_wr  = 1'b1;
      end
      default: ;
    endcase
  end

  assign class_o  = cls;
  assign alu_op_o = alu_op;

  assign rf_read_o.rs1_en   = (src1_o == src_reg);
  assign rf_read_o.rs1_addr = (src1_o == src_reg) ? rs1 : '0;
  assign rf_read_o.rs2_en   = (src2_o == src_reg);
  assign rf_read_o.rs2_addr = (src2_o == src_reg) ? rs2 : '0;

  // x0 is never written
  assign rd_we_o   = rd_wr && (rd != '0);
  assign rd_addr_o = rd_we_o ? rd : '0;

endmodule

//--- operand_select.sv
/*
  operand source selection for one operand
  forwarding from two ALU ports and the memory port
*/
module operand_select import id_pkg::*; (
  input  opnd_src_e             src_i,
  input  logic [REG_ADDR_W-1:0] addr_i,
  input  logic [XLEN-1:0]       rf_data_i,
  input  producer_t             alu1_i,
  input  producer_t             alu2_i,
  input  producer_t             mem_i,
  input  logic [XLEN-1:0]       imm_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic [XLEN-1:0]       opnd_o
);

  logic            addr_nz;
  logic            hit_alu1, hit_alu2, hit_mem;
  logic [XLEN-1:0] reg_val;

  assign addr_nz  = (addr_i != '0);
  assign hit_alu1 = addr_nz && alu1_i.rd_we && (alu1_i.rd_addr == addr_i);
  assign hit_alu2 = addr_nz && alu2_i.rd_we && (alu2_i.rd_addr == addr_i);
  assign hit_mem  = addr_nz && mem_i.rd_we && (mem_i.rd_addr == addr_i);

  always_comb begin
    if (hit_alu1 && hit_alu2) begin
      // younger producer has the larger pc
      reg_val = (alu1_i.pc >= alu2_i.pc) ? alu1_i.data : alu2_i.data;
    end else if (hit_alu1) begin
      reg_val = alu1_i.data;
    end else if (hit_alu2) begin
      reg_val = alu2_i.data;
    end else if (hit_mem) begin
      reg_val = mem_i.data;
    end else begin
      reg_val = rf_data_i;
    end
  end

  always_comb begin
    case (src_i)
      src_reg: opnd_o = reg_val;
      src_pc:  opnd_o = pc_i;
      src_imm: opnd_o = imm_i;
      default: opnd_o = '0;
    endcase
  end

endmodule

//--- branch_resolve.sv
/*
  branch compare and mispredict redirect
  jalr target redirect, history update, load/store address
*/
module branch_resolve import id_pkg::*; #(
  parameter int NUM_WB = 3
) (
  input  logic                          valid_i,
  input  logic                          stall_i,
  input  inst_class_e                   class_i,
  input  alu_op_e                       alu_op_i,
  input  logic [XLEN-1:0]               op1_i,
  input  logic [XLEN-1:0]               op2_i,
  input  logic [XLEN-1:0]               pc_i,
  input  logic [XLEN-1:0]               imm_i,
  input  logic [XLEN-1:0]               b_imm_i,
  input  logic [REG_ADDR_W-1:0]         rs1_addr_i,
  input  logic                          phb_i,
  input  producer_t                     alu1_i,
  input  producer_t                     alu2_i,
  input  producer_t                     mem_i,
  input  wb_pending_t [NUM_WB-1:0]      wb_i,
  output redirect_t                     redirect_o,
  output bht_update_t                   bht_update_o,
  output logic [XLEN-1:0]               mem_addr_o
);

  logic            fire;
  logic            is_branch;
  logic            taken;
  logic            mispredict;
  logic            rs1_busy;
  logic            jalr_redir;
  logic [XLEN-1:0] branch_target;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] addr_sum;

  assign fire      = valid_i && !stall_i;
  assign is_branch = (class_i == cls_branch);

  always_comb begin
    case (alu_op_i)
      alu_beq:  taken = (op1_i == op2_i);
      alu_bne:  taken = (op1_i != op2_i);
      alu_blt:  taken = ($signed(op1_i) < $signed(op2_i));
      alu_bge:  taken = ($signed(op1_i) >= $signed(op2_i));
      alu_bltu: taken = (op1_i < op2_i);
      alu_bgeu: taken = (op1_i >= op2_i);
      default:  taken = 1'b0;
    endcase
  end

  assign mispredict    = is_branch && (taken != phb_i);
  // predicted taken but falls through, or the reverse
  assign branch_target = phb_i ? pc_i + XLEN'(4) : pc_i + b_imm_i;

  // fetch cannot know the jalr target while rs1 is still in flight
  always_comb begin
    rs1_busy = (alu1_i.rd_we && alu1_i.rd_addr == rs1_addr_i) ||
               (alu2_i.rd_we && alu2_i.rd_addr == rs1_addr_i) ||
               (mem_i.rd_we && mem_i.rd_addr == rs1_addr_i);
    for (int i = 0; i < NUM_WB; i++) begin
      if (wb_i[i].en && wb_i[i].addr == rs1_addr_i) begin
        rs1_busy = 1'b1;
      end
    end
    // x0 target is static
    if (rs1_addr_i == '0) begin
      rs1_busy = 1'b0;
    end
  end

  assign jalr_redir = (class_i == cls_jalr) && rs1_busy;
  assign jalr_sum   = op1_i + imm_i;

  always_comb begin
    redirect_o.en     = fire && (mispredict || jalr_redir);
    redirect_o.target = '0;
    if (mispredict) begin
      redirect_o.target = branch_target;
    end else if (jalr_redir) begin
      redirect_o.target = {jalr_sum[XLEN-1:1], 1'b0};
    end
  end

  assign bht_update_o.en    = fire && is_branch;
  assign bht_update_o.idx   = pc_i[BHT_IDX_W+1:2];
  assign bht_update_o.taken = taken;

  assign addr_sum   = op1_i + imm_i;
  assign mem_addr_o = (class_i == cls_load || class_i == cls_store) ? addr_sum : '0;

endmodule

//--- id_ex_reg.sv
/*
  ID/EX pipeline register
  holds on stall, drops valid on idle cycles
*/
module id_ex_reg import id_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   valid_i,
  input  logic   stall_i,
  input  id_ex_t d_i,
  output id_ex_t q_o,
  output logic   valid_o
);

  id_ex_t q;
  logic   valid;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid <= 1'b0;
    end else if (!stall_i) begin
      valid <= valid_i;
    end
  end

  // payload only loads on an accepted instruction
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      q <= '0;
    end else if (valid_i && !stall_i) begin
      q <= d_i;
    end
  end

  assign q_o     = q;
  assign valid_o = valid;

endmodule

//--- id_stage.sv
/*
  instruction decode stage top level
  decoder, two operand selectors, branch unit, ID/EX register
*/
module id_stage import id_pkg::*; #(
  parameter int NUM_WB = 3
) (
  input  logic                     clk,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [31:0]              inst_i,
  input  logic [XLEN-1:0]          pc_i,
  input  logic                     phb_i,
  input  logic [XLEN-1:0]          op1_data_i,
  input  logic [XLEN-1:0]          op2_data_i,
  input  producer_t                alu1_i,
  input  producer_t                alu2_i,
  input  producer_t                mem_i,
  input  wb_pending_t [NUM_WB-1:0] wb_i,
  input  logic                     stall_i,
  output rf_read_t                 rf_read_o,
  output redirect_t                redirect_o,
  output bht_update_t              bht_update_o,
  output id_ex_t                   id_ex_o,
  output logic                     id_ex_valid_o
);

  inst_class_e           cls;
  alu_op_e               alu_op;
  exec_unit_e            unit;
  opnd_src_e             src1, src2;
  logic [XLEN-1:0]       imm, b_imm;
  logic [XLEN-1:0]       op1, op2;
  logic [XLEN-1:0]       mem_addr;
  logic                  rd_we;
  logic [REG_ADDR_W-1:0] rd_addr;
  logic [2:0]            mem_size;
  id_ex_t                id_ex_d;

  inst_decoder u_dec (
    .inst_i     (inst_i),
    .pc_i       (pc_i),
    .class_o    (cls),
    .alu_op_o   (alu_op),
    .unit_o     (unit),
    .rf_read_o  (rf_read_o),
    .src1_o     (src1),
    .src2_o     (src2),
    .imm_o      (imm),
    .b_imm_o    (b_imm),
    .rd_we_o    (rd_we),
    .rd_addr_o  (rd_addr),
    .mem_size_o (mem_size)
  );

  operand_select u_opnd1 (
    .src_i     (src1),
    .addr_i    (rf_read_o.rs1_addr),
    .rf_data_i (op1_data_i),
    .alu1_i    (alu1_i),
    .alu2_i    (alu2_i),
    .mem_i     (mem_i),
    .imm_i     (imm),
    .pc_i      (pc_i),
    .opnd_o    (op1)
  );

  operand_select u_opnd2 (
    .src_i     (src2),
    .addr_i    (rf_read_o.rs2_addr),
    .rf_data_i (op2_data_i),
    .alu1_i    (alu1_i),
    .alu2_i    (alu2_i),
    .mem_i     (mem_i),
    .imm_i     (imm),
    .pc_i      (pc_i),
    .opnd_o    (op2)
  );

  branch_resolve #(
    .NUM_WB (NUM_WB)
  ) u_bru (
    .valid_i      (valid_i),
    .stall_i      (stall_i),
    .class_i      (cls),
    .alu_op_i     (alu_op),
    .op1_i        (op1),
    .op2_i        (op2),
    .pc_i         (pc_i),
    .imm_i        (imm),
    .b_imm_i      (b_imm),
    .rs1_addr_i   (rf_read_o.rs1_addr),
    .phb_i        (phb_i),
    .alu1_i       (alu1_i),
    .alu2_i       (alu2_i),
    .mem_i        (mem_i),
    .wb_i         (wb_i),
    .redirect_o   (redirect_o),
    .bht_update_o (bht_update_o),
    .mem_addr_o   (mem_addr)
  );

  assign id_ex_d = '{
    pc:       pc_i,
    alu_op:   alu_op,
    unit:     unit,
    op1:      op1,
    op2:      op2,
    rd_we:    rd_we,
    rd_addr:  rd_addr,
    mem_addr: mem_addr,
    mem_size: mem_size
  };

  id_ex_reg u_id_ex (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .stall_i (stall_i),
    .d_i     (id_ex_d),
    .q_o     (id_ex_o),
    .valid_o (id_ex_valid_o)
  );

endmodule

//--- tb_ref_model.svh
/*
  reference model of the decode stage
  operand forwarding, register reads, expected ID/EX word,
  redirect and history update
*/

function automatic logic [XLEN-1:0] forward_value(
  input logic [REG_ADDR_W-1:0] addr,
  input logic [XLEN-1:0]       rf,
  input producer_t             a1,
  input producer_t             a2,
  input producer_t             m
);
  logic            h1;
  logic            h2;
  logic            hm;
  logic [XLEN-1:0] val;
  h1 = (addr != 0) && a1.rd_we && (a1.rd_addr == addr);
  h2 = (addr != 0) && a2.rd_we && (a2.rd_addr == addr);
  hm = (addr != 0) && m.rd_we && (m.rd_addr == addr);
  if (h1 && h2) begin
    // the younger ALU result has the larger pc
    val = (a2.pc > a1.pc) ? a2.data : a1.data;
  end else if (h1) begin
    val = a1.data;
  end else if (h2) begin
    val = a2.data;
  end else if (hm) begin
    val = m.data;
  end else begin
    val = rf;
  end
  return val;
endfunction

function automatic void ref_decode(
  input  logic [31:0]              inst,
  input  logic [XLEN-1:0]          pc,
  input  logic                     phb,
  input  logic                     fire,
  input  logic [XLEN-1:0]          rf1,
  input  logic [XLEN-1:0]          rf2,
  input  producer_t                a1,
  input  producer_t                a2,
  input  producer_t                m,
  input  wb_pending_t [NUM_WB-1:0] wb,
  output id_ex_t                   ie,
  output redirect_t                rd,
  output bht_update_t              bu,
  output rf_read_t                 rr
);
  alu_op_e         arith [8] = '{alu_add, alu_sll, alu_slt, alu_sltu,
                                 alu_xor, alu_srl, alu_or, alu_and};
  alu_op_e         cmp [8]   = '{alu_beq, alu_bne, alu_nop, alu_nop,
                                 alu_blt, alu_bge, alu_bltu, alu_bgeu};
  logic [2:0]      f3;
  logic [4:0]      rs1;
  logic [4:0]      rd_a;
  logic [XLEN-1:0] i_imm, s_imm, u_imm, b_imm;
  logic [XLEN-1:0] v1, v2, jsum;
  logic            writes;
  logic            taken;
  logic            busy;
  logic            use1;
  logic            use2;
  f3     = inst[14:12];
  rs1    = inst[19:15];
  rd_a   = inst[11:7];
  i_imm  = {{52{inst[31]}}, inst[31:20]};
  s_imm  = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  u_imm  = {{32{inst[31]}}, inst[31:12], 12'h000};
  b_imm  = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  v1     = forward_value(rs1, rf1, a1, a2, m);
  v2     = forward_value(inst[24:20], rf2, a1, a2, m);
  writes = 1'b1;
  taken  = 1'b0;
  use1   = 1'b0;
  use2   = 1'b0;
  ie     = '0;
  rd     = '0;
  bu     = '0;
  rr     = '0;
  ie.pc  = pc;
  case (inst[6:0])
    7'b0110011, 7'b0010011: begin
      // bit 5 set means register-register
      ie.alu_op = arith[f3];
      if (inst[30] && f3 == 3'b101) begin
        ie.alu_op = alu_sra;
      end
      if (inst[30] && f3 == 3'b000 && inst[5]) begin
        ie.alu_op = alu_sub;
      end
      ie.unit = unit_alu;
      ie.op1  = v1;
      ie.op2  = inst[5] ? v2 : i_imm;
      use1    = 1'b1;
      use2    = inst[5];
    end
    7'b1100011: begin
      ie.alu_op = cmp[f3];
      ie.unit   = unit_bru;
      ie.op1    = v1;
      ie.op2    = v2;
      writes    = 1'b0;
      use1      = 1'b1;
      use2      = 1'b1;
      case (f3)
        3'b000:  taken = (v1 == v2);
        3'b001:  taken = (v1 != v2);
        3'b100:  taken = ($signed(v1) < $signed(v2));
        3'b101:  taken = ($signed(v1) >= $signed(v2));
        3'b110:  taken = (v1 < v2);
        default: taken = (v1 >= v2);
      endcase
      rd.en     = fire && (taken != phb);
      rd.target = phb ? pc + 64'd4 : pc + b_imm;
      bu.en     = fire;
    end
    7'b0000011: begin
      ie.alu_op   = alu_load;
      ie.unit     = unit_lsu;
      ie.op1      = v1;
      ie.mem_addr = v1 + i_imm;
      ie.mem_size = f3;
      use1        = 1'b1;
    end
    7'b0100011: begin
      ie.alu_op   = alu_store;
      ie.unit     = unit_lsu;
      ie.op1      = v1;
      ie.op2      = v2;
      ie.mem_addr = v1 + s_imm;
      ie.mem_size = f3;
      writes      = 1'b0;
      use1        = 1'b1;
      use2        = 1'b1;
    end
    7'b0110111, 7'b0010111: begin
      ie.alu_op = inst[5] ? alu_lui : alu_auipc;
      ie.unit   = unit_alu;
      ie.op1    = inst[5] ? '0 : pc;
      ie.op2    = u_imm;
    end
    7'b1101111: begin
      ie.alu_op = alu_jal;
      ie.unit   = unit_bru;
      ie.op1    = pc;
      ie.op2    = pc;
    end
    7'b1100111: begin
      ie.alu_op = alu_jalr;
      ie.unit   = unit_bru;
      ie.op1    = v1;
      ie.op2    = pc;
      use1      = 1'b1;
      busy = (a1.rd_we && a1.rd_addr == rs1) || (a2.rd_we && a2.rd_addr == rs1) ||
             (m.rd_we && m.rd_addr == rs1);
      for (int i = 0; i < NUM_WB; i++) begin
        busy = busy || (wb[i].en && wb[i].addr == rs1);
      end
      jsum      = v1 + i_imm;
      rd.en     = fire && busy && (rs1 != 0);
      rd.target = {jsum[XLEN-1:1], 1'b0};
    end
    default: begin
      ie.alu_op = alu_nop;
      ie.unit   = unit_none;
      writes    = 1'b0;
    end
  endcase
  ie.rd_we    = writes && (rd_a != 0);
  ie.rd_addr  = ie.rd_we ? rd_a : 5'd0;
  bu.idx      = pc[5:2];
  bu.taken    = taken;
  // unread ports carry address 0
  rr.rs1_en   = use1;
  rr.rs1_addr = use1 ? rs1 : 5'd0;
  rr.rs2_en   = use2;
  rr.rs2_addr = use2 ? inst[24:20] : 5'd0;
endfunction

//--- tb_id_stage.sv
/*
  testbench for the instruction decode stage
  clock, reset, stimulus tasks, comparison process, timeout, report
*/
module tb_id_stage import id_pkg::*; ();

  localparam int NUM_WB       = 3;
  localparam int RESET_CYCLES = 10;
  localparam int N_ALU        = 40;
  localparam int N_BR_REP     = 2;
  localparam int N_JUMP       = 24;
  localparam int N_MEM        = 20;
  // instruction cycles per test plus two drain cycles each
  localparam int TEST_CYCLES  = 2 * (N_ALU + 2) + (12 * N_BR_REP + 2) +
                                (N_JUMP + 2) + (N_MEM + 2) + 10;
  localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES + RESET_CYCLES;

  logic                     clk;
  logic                     rst_n_i;
  logic                     valid_i;
  logic [31:0]              inst_i;
  logic [XLEN-1:0]          pc_i;
  logic                     phb_i;
  logic [XLEN-1:0]          op1_data_i;
  logic [XLEN-1:0]          op2_data_i;
  producer_t                alu1_i, alu2_i, mem_i;
  wb_pending_t [NUM_WB-1:0] wb_i;
  logic                     stall_i;
  rf_read_t                 rf_read_o;
  redirect_t                redirect_o;
  bht_update_t              bht_update_o;
  id_ex_t                   id_ex_o;
  logic                     id_ex_valid_o;

  integer seed = 41;
  int     errors, checks, tests, test_start, cycles;
  id_ex_t exp_q[$];
  id_ex_t held_ie;
  logic   exp_valid;

`include "tb_ref_model.svh"

  id_stage #(
    .NUM_WB (NUM_WB)
  ) u_dut (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .valid_i       (valid_i),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .phb_i         (phb_i),
    .op1_data_i    (op1_data_i),
    .op2_data_i    (op2_data_i),
    .alu1_i        (alu1_i),
    .alu2_i        (alu2_i),
    .mem_i         (mem_i),
    .wb_i          (wb_i),
    .stall_i       (stall_i),
    .rf_read_o     (rf_read_o),
    .redirect_o    (redirect_o),
    .bht_update_o  (bht_update_o),
    .id_ex_o       (id_ex_o),
    .id_ex_valid_o (id_ex_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // outputs are sampled mid-cycle, inputs move 2 after the rising edge
  always @(negedge clk) begin
    id_ex_t      exp_ie;
    redirect_t   exp_rd;
    bht_update_t exp_bu;
    rf_read_t    exp_rr;
    logic        fire;
    if (rst_n_i) begin
      if (exp_q.size() > 0) begin
        held_ie = exp_q.pop_front();
      end
      checks++;
      if (id_ex_valid_o !== exp_valid || id_ex_o !== held_ie) begin
        errors++;
        $display("Error %0t: id_ex valid %0b expected %0b, word %h expected %h",
                 $time, id_ex_valid_o, exp_valid, id_ex_o, held_ie);
      end
      fire = valid_i && !stall_i;
      ref_decode(inst_i, pc_i, phb_i, fire, op1_data_i, op2_data_i,
                 alu1_i, alu2_i, mem_i, wb_i, exp_ie, exp_rd, exp_bu, exp_rr);
      checks++;
      if (rf_read_o !== exp_rr) begin
        errors++;
        $display("Error %0t: inst %h register read %h expected %h",
                 $time, inst_i, rf_read_o, exp_rr);
      end
      checks++;
      if (redirect_o.en !== exp_rd.en ||
          (exp_rd.en && redirect_o.target !== exp_rd.target)) begin
        errors++;
        $display("Error %0t: inst %h redirect %0b/%h expected %0b/%h", $time, inst_i,
                 redirect_o.en, redirect_o.target, exp_rd.en, exp_rd.target);
      end
      checks++;
      if (bht_update_o !== exp_bu) begin
        errors++;
        $display("Error %0t: inst %h history update %h expected %h",
                 $time, inst_i, bht_update_o, exp_bu);
      end
      if (!stall_i) begin
        exp_valid = valid_i;
      end
      if (fire) begin
        exp_q.push_back(exp_ie);
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  function automatic logic [XLEN-1:0] random_pc();
    return {$random(seed), $random(seed) & 32'hffff_fffc};
  endfunction

  task automatic apply(input logic [31:0] inst, input logic [XLEN-1:0] pc,
                       input logic phb);
    @(posedge clk);
    #2;
    valid_i    = 1'b1;
    inst_i     = inst;
    pc_i       = pc;
    phb_i      = phb;
    op1_data_i = {$random(seed), $random(seed)};
    op2_data_i = {$random(seed), $random(seed)};
  endtask

  task automatic idle();
    @(posedge clk);
    #2;
    valid_i = 1'b0;
  endtask

  // small address range so that producers often hit
  task automatic randomize_producers(input logic on);
    producer_t   p [3];
    logic [31:0] r;
    for (int i = 0; i < 3; i++) begin
      r            = $random(seed);
      p[i].rd_we   = on & r[0];
      p[i].rd_addr = {2'b00, r[3:1]};
      p[i].pc      = random_pc();
      p[i].data    = {$random(seed), $random(seed)};
    end
    alu1_i = p[0];
    alu2_i = p[1];
    mem_i  = p[2];
    for (int i = 0; i < NUM_WB; i++) begin
      r          = $random(seed);
      wb_i[i].en   = on & r[0];
      wb_i[i].addr = {2'b00, r[3:1]};
    end
  endtask

  task automatic drain_and_report(input string name);
    idle();
    idle();
    tests++;
    if (errors == test_start) begin
      $display("%-8s ok", name);
    end else begin
      $display("%-8s FAILED with %0d errors", name, errors - test_start);
    end
    test_start = errors;
  endtask

  task automatic run_alu_test(input string name, input logic fwd);
    logic [31:0] r;
    logic [31:0] inst;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    for (int i = 0; i < N_ALU; i++) begin
      r   = $random(seed);
      f3  = r[14:12];
      rd  = (i % 8 == 0) ? 5'd0 : r[11:7];
      rs1 = fwd ? {2'b00, r[17:15]} : r[19:15];
      rs2 = fwd ? {2'b00, r[22:20]} : r[24:20];
      if (i % 2 == 0) begin
        inst = {1'b0, r[30] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                rs2, rs1, f3, rd, 7'b0110011};
      end else begin
        inst = {r[31:20], rs1, f3, rd, 7'b0010011};
        if (f3 == 3'b001) begin
          inst[31:26] = 6'b0;
        end
        if (f3 == 3'b101) begin
          inst[31:26] = {1'b0, r[30], 4'b0};
        end
      end
      apply(inst, random_pc(), 1'b0);
      randomize_producers(fwd);
    end
    drain_and_report(name);
  endtask

  task automatic run_branch_test();
    logic [31:0] r;
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        for (int k = 0; k < 2 * N_BR_REP; k++) begin
          r = $random(seed);
          apply({r[31:15], 3'(f), r[11:7], 7'b1100011}, random_pc(), k[0]);
          randomize_producers(1'b0);
          // equal operands give the other outcome for most compares
          if (k[1]) begin
            op2_data_i = op1_data_i;
          end
        end
      end
    end
    drain_and_report("branch");
  endtask

  task automatic run_jump_test();
    logic [31:0] r;
    logic [31:0] inst;
    for (int i = 0; i < N_JUMP; i++) begin
      r = $random(seed);
      case (i % 4)
        0:       inst = {r[31:20], 2'b00, r[17:15], 3'b000, r[11:7], 7'b1100111};
        1:       inst = {r[31:12], r[11:7], 7'b1101111};
        2:       inst = {r[31:12], r[11:7], 7'b0110111};
        default: inst = {r[31:12], r[11:7], 7'b0010111};
      endcase
      apply(inst, random_pc(), 1'b0);
      randomize_producers(1'b1);
    end
    drain_and_report("jump");
  endtask

  task automatic run_mem_test();
    logic [31:0] r;
    logic [31:0] inst;
    logic [2:0]  f3;
    for (int i = 0; i < N_MEM; i++) begin
      r  = $random(seed);
      f3 = (r[14:12] == 3'b111) ? 3'b011 : r[14:12];
      if (i % 2 == 0) begin
        inst = {r[31:20], 2'b00, r[17:15], f3, r[11:7], 7'b0000011};
      end else begin
        inst = {r[31:20], 2'b00, r[17:15], 1'b0, r[13:12], r[11:7], 7'b0100011};
      end
      apply(inst, random_pc(), 1'b0);
      randomize_producers(1'b1);
    end
    drain_and_report("memory");
  endtask

  task automatic run_stall_test();
    // add x3, x1, x2 goes through, then a beq that mispredicts
    apply({7'b0, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011}, random_pc(), 1'b0);
    randomize_producers(1'b0);
    apply({7'b0, 5'd2, 5'd1, 3'b000, 5'b01000, 7'b1100011}, random_pc(), 1'b0);
    op2_data_i = op1_data_i;
    stall_i    = 1'b1;
    repeat (3) begin
      @(posedge clk);
    end
    #2;
    stall_i = 1'b0;
    drain_and_report("stall");
  endtask

  initial begin
    rst_n_i    = 1'b0;
    valid_i    = 1'b0;
    inst_i     = '0;
    pc_i       = '0;
    phb_i      = 1'b0;
    op1_data_i = '0;
    op2_data_i = '0;
    alu1_i     = '0;
    alu2_i     = '0;
    mem_i      = '0;
    wb_i       = '0;
    stall_i    = 1'b0;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    test_start = 0;
    cycles     = 0;
    held_ie    = '0;
    exp_valid  = 1'b0;
    repeat (RESET_CYCLES) begin
      @(posedge clk);
    end
    #2;
    rst_n_i = 1'b1;
    run_alu_test("decode", 1'b0);
    run_alu_test("forward", 1'b1);
    run_branch_test();
    run_jump_test();
    run_mem_test();
    run_stall_test();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+.
id_pkg.sv
inst_decoder.sv
operand_select.sv
branch_resolve.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_id_stage
FILELIST := all.f
LOG      := sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
